//--- hdl/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
	localparam int dmem_words = 256;
	localparam int dmem_aw = $clog2(dmem_words); // word address bits

	// major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} op_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b // lui
	} alu_op_e;

	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} br_op_e;

	typedef enum logic [1:0] {
		mem_byte = 2'b00,
		mem_half = 2'b01,
		mem_word = 2'b10
	} mem_size_e;

endpackage

//--- hdl/rv_decode.sv
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
	input logic [31:0] instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [xlen-1:0] imm,
	output op_class_e op_class,
	output alu_op_e alu_op,
	output br_op_e br_op,
	output mem_size_e mem_size,
	output logic load_unsigned,
	output logic use_imm,
	output logic rd_wen,
	output logic illegal
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign load_unsigned = funct3[2];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op_class = opc_op_imm;
		alu_op = alu_add;
		br_op = br_beq;
		mem_size = mem_word;
		use_imm = 1'b1;
		rd_wen = 1'b0;
		illegal = 1'b0;
		imm = imm_i;
		case (instr[6:0])
			opc_lui: begin
				op_class = opc_lui;
				alu_op = alu_pass_b;
				imm = imm_u;
				rd_wen = 1'b1;
			end
			opc_auipc: begin
				op_class = opc_auipc;
				imm = imm_u;
				rd_wen = 1'b1;
			end
			opc_jal: begin
				op_class = opc_jal;
				imm = imm_j;
				rd_wen = 1'b1;
			end
			opc_jalr: begin
				op_class = opc_jalr;
				rd_wen = 1'b1;
				illegal = funct3 != 3'b000;
			end
			opc_branch: begin
				op_class = opc_branch;
				br_op = br_op_e'(funct3);
				imm = imm_b;
				use_imm = 1'b0;
				illegal = funct3[2:1] == 2'b01; // 010, 011 unused
			end
			opc_load: begin
				op_class = opc_load;
				mem_size = mem_size_e'(funct3[1:0]);
				rd_wen = 1'b1;
				illegal = funct3[1:0] == 2'b11 || funct3 == 3'b110;
			end
			opc_store: begin
				op_class = opc_store;
				mem_size = mem_size_e'(funct3[1:0]);
				imm = imm_s;
				illegal = funct3[2] || funct3[1:0] == 2'b11;
			end
			opc_op_imm: begin
				op_class = opc_op_imm;
				alu_op = alu_sel(funct3, instr[30] && funct3 == 3'b101); // addi ignores bit 30
				rd_wen = 1'b1;
				if (funct3 == 3'b001)
					illegal = funct7 != 7'b0000000;
				else if (funct3 == 3'b101)
					illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
			end
			opc_op: begin
				op_class = opc_op;
				alu_op = alu_sel(funct3, instr[30]);
				use_imm = 1'b0;
				rd_wen = 1'b1;
				if (funct7 == 7'b0100000)
					illegal = funct3 != 3'b000 && funct3 != 3'b101; // only sub, sra
				else
					illegal = funct7 != 7'b0000000;
			end
			default: illegal = 1'b1;
		endcase
		// retire as a no-op
		if (illegal) begin
			op_class = opc_op_imm;
			alu_op = alu_add;
			rd_wen = 1'b0;
		end
	end

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input logic [4:0] rd,
	input logic wen,
	input logic [xlen-1:0] wdata
);

	logic [xlen-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

	a_no_wen_in_rst: assert property (@(posedge clk) rst |-> !wen); // writes held off in reset

endmodule

//--- hdl/rv_exu.sv
`timescale 1ns/100ps

module rv_exu import rv_pkg::*; (
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rs1_data,
	input logic [xlen-1:0] rs2_data,
	input logic [xlen-1:0] imm,
	input op_class_e op_class,
	input alu_op_e alu_op,
	input br_op_e br_op,
	input logic use_imm,
	output logic [xlen-1:0] result,
	output logic taken,
	output logic [xlen-1:0] target,
	output logic [xlen-1:0] addr
);

	logic [xlen-1:0] opb;
	logic [xlen-1:0] alu_out;
	logic [4:0] shamt;
	logic [xlen-1:0] pc_plus4;
	logic br_cond;
	logic lt_s;
	logic lt_u;

	assign opb = use_imm ? imm : rs2_data;
	assign shamt = opb[4:0]; // low five bits only
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (alu_op)
			alu_add: alu_out = rs1_data + opb;
			alu_sub: alu_out = rs1_data - opb;
			alu_sll: alu_out = rs1_data << shamt;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(opb)};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, rs1_data < opb};
			alu_xor: alu_out = rs1_data ^ opb;
			alu_srl: alu_out = rs1_data >> shamt;
			alu_sra: alu_out = $signed(rs1_data) >>> shamt;
			alu_or: alu_out = rs1_data | opb;
			alu_and: alu_out = rs1_data & opb;
			alu_pass_b: alu_out = opb;
			default: alu_out = '0;
		endcase
	end

	// branches always compare the two registers
	assign lt_s = $signed(rs1_data) < $signed(rs2_data);
	assign lt_u = rs1_data < rs2_data;

	always_comb begin
		case (br_op)
			br_beq: br_cond = rs1_data == rs2_data;
			br_bne: br_cond = rs1_data != rs2_data;
			br_blt: br_cond = lt_s;
			br_bge: br_cond = !lt_s;
			br_bltu: br_cond = lt_u;
			br_bgeu: br_cond = !lt_u;
			default: br_cond = 1'b0;
		endcase
	end

	always_comb begin
		case (op_class)
			opc_auipc: result = pc + imm;
			opc_jal, opc_jalr: result = pc_plus4; // link
			default: result = alu_out;
		endcase
	end

	always_comb begin
		case (op_class)
			opc_branch: taken = br_cond;
			opc_jal, opc_jalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign addr = rs1_data + imm;
	assign target = (op_class == opc_jalr) ? {addr[xlen-1:1], 1'b0} : pc + imm;

	// pc alignment kept by the core makes every redirect even
	always_comb begin
		if (taken)
			a_target_even: assert (!target[0]);
	end

endmodule

//--- hdl/rv_dmem.sv
`timescale 1ns/100ps

module rv_dmem import rv_pkg::*; (
	input logic clk,
	input logic [xlen-1:0] addr,
	input logic [xlen-1:0] wdata,
	input mem_size_e mem_size,
	input logic load_unsigned,
	input logic wen,
	output logic [xlen-1:0] rdata
);

	logic [xlen-1:0] mem [dmem_words];
	logic [dmem_aw-1:0] widx;
	logic [3:0] lane_mask;
	logic [xlen-1:0] lane_data;
	logic [xlen-1:0] word;
	logic [7:0] rbyte;
	logic [15:0] rhalf;

	assign widx = addr[dmem_aw+1:2]; // wraps modulo dmem_words

	always_comb begin
		case (mem_size)
			mem_byte: begin
				lane_mask = 4'b0001 << addr[1:0];
				lane_data = {4{wdata[7:0]}};
			end
			mem_half: begin
				lane_mask = addr[1] ? 4'b1100 : 4'b0011; // bit 0 ignored
				lane_data = {2{wdata[15:0]}};
			end
			mem_word: begin
				lane_mask = 4'b1111;
				lane_data = wdata;
			end
			default: begin
				lane_mask = 4'b0000;
				lane_data = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			for (int i = 0; i < 4; i++)
				if (lane_mask[i])
					mem[widx][8*i +: 8] <= lane_data[8*i +: 8];
		end
	end

	assign word = mem[widx];
	assign rbyte = word[{addr[1:0], 3'b000} +: 8];
	assign rhalf = addr[1] ? word[31:16] : word[15:0];

	always_comb begin
		case (mem_size)
			mem_byte: rdata = load_unsigned ? {24'b0, rbyte} : {{24{rbyte[7]}}, rbyte};
			mem_half: rdata = load_unsigned ? {16'b0, rhalf} : {{16{rhalf[15]}}, rhalf};
			default: rdata = word;
		endcase
	end

	a_lanes: assert property (@(posedge clk) wen |-> lane_mask inside
		{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111});

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic rst,
	output logic [xlen-1:0] pc,
	input logic [31:0] instr,
	output logic retire_wen,
	output logic [4:0] retire_rd,
	output logic [xlen-1:0] retire_data,
	output logic [xlen-1:0] retire_next_pc,
	output logic illegal
);

	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [xlen-1:0] imm;
	op_class_e op_class;
	alu_op_e alu_op;
	br_op_e br_op;
	mem_size_e mem_size;
	logic load_unsigned;
	logic use_imm;
	logic rd_wen;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] result;
	logic taken;
	logic [xlen-1:0] target;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] load_data;
	logic reg_wen;
	logic mem_wen;
	logic [xlen-1:0] wb_data;
	logic [xlen-1:0] next_pc;

	rv_decode u_decode (
		.instr(instr),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.imm(imm),
		.op_class(op_class),
		.alu_op(alu_op),
		.br_op(br_op),
		.mem_size(mem_size),
		.load_unsigned(load_unsigned),
		.use_imm(use_imm),
		.rd_wen(rd_wen),
		.illegal(illegal)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rd(rd),
		.wen(reg_wen),
		.wdata(wb_data)
	);

	rv_exu u_exu (
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.op_class(op_class),
		.alu_op(alu_op),
		.br_op(br_op),
		.use_imm(use_imm),
		.result(result),
		.taken(taken),
		.target(target),
		.addr(addr)
	);

	rv_dmem u_dmem (
		.clk(clk),
		.addr(addr),
		.wdata(rs2_data),
		.mem_size(mem_size),
		.load_unsigned(load_unsigned),
		.wen(mem_wen),
		.rdata(load_data)
	);

	assign reg_wen = rd_wen && !illegal && !rst;
	assign mem_wen = op_class == opc_store && !illegal && !rst;
	assign wb_data = (op_class == opc_load) ? load_data : result;
	assign next_pc = (taken && !illegal) ? target : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= reset_pc;
		else
			pc <= next_pc;
	end

	assign retire_wen = reg_wen;
	assign retire_rd = rd;
	assign retire_data = wb_data;
	assign retire_next_pc = next_pc;

	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- tests/tb_model.svh
// architectural state of the reference model
logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [7:0] m_mem [dmem_words * 4]; // byte addressed, wraps on bits 9:0
logic [31:0] rng_state = 32'h0e38c960;
logic exp_wen;
logic exp_ill;
logic [4:0] exp_rd;
logic [31:0] exp_data;
logic [31:0] exp_npc;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// low state bits cycle quickly, so hand out the upper half first
function automatic logic [31:0] rnd();
	rng_state = lcg_next(rng_state);
	return {rng_state[15:0], rng_state[31:16]};
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'b000: return alt ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return {31'b0, $signed(a) < $signed(b)};
		3'b011: return {31'b0, a < b};
		3'b100: return a ^ b;
		3'b101: begin
			if (alt)
				return $signed(a) >>> b[4:0];
			else
				return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

task automatic reset_model();
	m_pc = reset_pc;
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	for (int i = 0; i < dmem_words * 4; i++)
		m_mem[i] = '0;
endtask

task automatic execute_model(input logic [31:0] ins);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] ea;
	logic [9:0] hb;
	logic [9:0] hh;
	logic [9:0] wi;
	logic [2:0] f3;
	logic [6:0] f7;
	logic take;
	f3 = ins[14:12];
	f7 = ins[31:25];
	a = m_regs[ins[19:15]];
	b = m_regs[ins[24:20]];
	ea = a + {{20{ins[31]}}, ins[31:20]};
	if (ins[6:0] == 7'b0100011)
		ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]}; // S format offset
	hb = ea[9:0];
	hh = {ea[9:1], 1'b0};
	wi = {ea[9:2], 2'b00};
	take = 1'b0;
	exp_ill = 1'b0;
	exp_wen = 1'b1;
	exp_rd = ins[11:7];
	exp_data = '0;
	exp_npc = m_pc + 32'd4;
	case (ins[6:0])
		7'b0110111: exp_data = {ins[31:12], 12'b0};
		7'b0010111: exp_data = m_pc + {ins[31:12], 12'b0};
		7'b1101111: begin
			exp_data = m_pc + 32'd4;
			exp_npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		7'b1100111: begin
			exp_ill = f3 != 3'b000;
			exp_data = m_pc + 32'd4;
			exp_npc = ea & ~32'd1;
		end
		7'b1100011: begin
			exp_wen = 1'b0;
			case (f3)
				3'b000: take = a == b;
				3'b001: take = a != b;
				3'b100: take = $signed(a) < $signed(b);
				3'b101: take = $signed(a) >= $signed(b);
				3'b110: take = a < b;
				3'b111: take = a >= b;
				default: exp_ill = 1'b1;
			endcase
			if (take)
				exp_npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		end
		7'b0000011: begin
			case (f3)
				3'b000: exp_data = {{24{m_mem[hb][7]}}, m_mem[hb]};
				3'b100: exp_data = {24'b0, m_mem[hb]};
				3'b001: exp_data = {{16{m_mem[hh | 10'd1][7]}}, m_mem[hh | 10'd1], m_mem[hh]};
				3'b101: exp_data = {16'b0, m_mem[hh | 10'd1], m_mem[hh]};
				3'b010: exp_data = {m_mem[wi | 10'd3], m_mem[wi | 10'd2],
					m_mem[wi | 10'd1], m_mem[wi]};
				default: exp_ill = 1'b1;
			endcase
		end
		7'b0100011: begin
			exp_wen = 1'b0;
			exp_ill = f3 > 3'b010;
			if (f3 == 3'b000) begin
				m_mem[hb] = b[7:0];
			end else if (f3 == 3'b001) begin
				m_mem[hh] = b[7:0];
				m_mem[hh | 10'd1] = b[15:8];
			end else if (f3 == 3'b010) begin
				for (int i = 0; i < 4; i++)
					m_mem[wi | 10'(i)] = b[8*i +: 8];
			end
		end
		7'b0010011: begin
			if (f3 == 3'b001)
				exp_ill = f7 != 7'b0;
			else if (f3 == 3'b101)
				exp_ill = f7 != 7'b0 && f7 != 7'b0100000;
			exp_data = alu_result(f3, f3 == 3'b101 && f7[5],
				a, {{20{ins[31]}}, ins[31:20]});
		end
		7'b0110011: begin
			exp_ill = !(f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
			exp_data = alu_result(f3, f7[5], a, b);
		end
		default: exp_ill = 1'b1;
	endcase
	if (exp_ill) begin
		exp_wen = 1'b0; // no-op, falls through
		exp_npc = m_pc + 32'd4;
	end else if (exp_wen && exp_rd != 5'd0) begin
		m_regs[exp_rd] = exp_data;
	end
	m_pc = exp_npc;
endtask

task automatic build_program();
	logic [31:0] s;
	logic [31:0] a;
	logic [31:0] b;
	logic [2:0] f3;
	logic [1:0] sz;
	logic [4:0] k;
	logic [11:0] imm;
	logic [11:0] mimm;
	logic [12:0] boff;
	logic [20:0] joff;
	logic [9:0] t;
	int sel;
	for (int i = 0; i < imem_words; i++) begin
		s = rnd();
		a = rnd();
		b = rnd();
		sel = int'(s[15:0] % 16'd100);
		f3 = b[2:0];
		imm = b[14:3];
		mimm = {{5{b[9]}}, b[9:3]}; // -64..63, wraps to the top words
		sz = (b[1:0] == 2'b11) ? 2'b10 : b[1:0];
		boff = {6'b0, imm[4:0], 2'b00} + 13'd4; // forward only
		joff = {14'b0, imm[4:0], 2'b00} + 21'd4;
		t = 10'(i) + 10'd1 + {5'b0, imm[4:0]};
		k = 5'(i);
		if (i < 32) begin
			// zero every word that loads can reach
			imm = {{5{k[4]}}, k, 2'b00};
			prog[i] = {imm[11:5], 5'd0, 5'd0, 3'b010, imm[4:0], 7'b0100011};
		end else if (sel < 3) begin
			case (b[1:0])
				2'b00: prog[i] = {a[24:0], 7'b0001111}; // fence
				2'b01: prog[i] = {a[24:0], 7'b1110011}; // system
				default: prog[i] = {7'b0000001, a[17:0], 7'b0110011}; // muldiv
			endcase
		end else if (sel < 38) begin
			prog[i] = {(a[15] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
				a[14:10], a[9:5], f3, a[4:0], 7'b0110011};
		end else if (sel < 63) begin
			if (f3 == 3'b001)
				imm = {7'b0, imm[4:0]};
			else if (f3 == 3'b101)
				imm = {1'b0, a[15], 5'b0, imm[4:0]};
			prog[i] = {imm, a[9:5], f3, a[4:0], 7'b0010011};
		end else if (sel < 68) begin
			prog[i] = {b[14:3], a[15:8], a[4:0], a[15] ? 7'b0110111 : 7'b0010111};
		end else if (sel < 78) begin
			if (f3[2:1] == 2'b01)
				f3[2] = 1'b1;
			prog[i] = {boff[12], boff[10:5], a[14:10], a[9:5], f3, boff[4:1], boff[11],
				7'b1100011};
		end else if (sel < 80) begin
			prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], a[4:0], 7'b1101111};
		end else if (sel < 82) begin
			prog[i] = {t, 1'b0, b[15], 5'd0, 3'b000, a[4:0], 7'b1100111}; // x0 base
		end else if (sel < 91) begin
			prog[i] = {mimm[11:5], a[14:10], 5'd0, 1'b0, sz, mimm[4:0], 7'b0100011};
		end else begin
			prog[i] = {mimm, 5'd0, b[15] && sz != 2'b10, sz, a[4:0], 7'b0000011};
		end
	end
endtask

//--- tests/tb_core.sv
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

	localparam int imem_words = 1024;
	localparam int num_instr = 2000;
	localparam int reset_cycles = 8;
	localparam int timeout_cycles = num_instr + reset_cycles + 100;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic [31:0] pc;
	logic retire_wen;
	logic [4:0] retire_rd;
	logic [31:0] retire_data;
	logic [31:0] retire_next_pc;
	logic illegal;
	logic [31:0] prog [imem_words];
	logic [31:0] cur_pc;
	int cycles = 0;

	`include "tb_model.svh"

	rv_core uut (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.instr(instr),
		.retire_wen(retire_wen),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.retire_next_pc(retire_next_pc),
		.illegal(illegal)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		reset_model();
		build_program();
		for (int c = 1; c <= reset_cycles; c++) begin
			@(posedge clk);
			#1;
			check_value("reset pc", reset_pc, pc);
			if (c < reset_cycles) begin
				instr = {20'(c), 5'(c), 7'b0110111}; // lui into x1..x7
				@(negedge clk);
				check_value("retire_wen in reset", 32'd0, {31'b0, retire_wen});
			end
		end
		rst = 1'b0;
		for (int n = 0; n < num_instr; n++) begin
			check_value("pc", m_pc, pc);
			instr = prog[pc[11:2]];
			@(negedge clk); // outputs settled, edge not yet reached
			cur_pc = m_pc;
			execute_model(instr);
			check_value($sformatf("illegal at pc %h", cur_pc), {31'b0, exp_ill},
				{31'b0, illegal});
			check_value($sformatf("retire_wen at pc %h", cur_pc), {31'b0, exp_wen},
				{31'b0, retire_wen});
			if (exp_wen) begin
				check_value($sformatf("retire_rd at pc %h", cur_pc), {27'b0, exp_rd},
					{27'b0, retire_rd});
				check_value($sformatf("retire_data at pc %h", cur_pc), exp_data,
					retire_data);
			end
			check_value($sformatf("retire_next_pc at pc %h", cur_pc), exp_npc,
				retire_next_pc);
			@(posedge clk);
			#1;
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- project.f
+incdir+tests
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_exu.sv
hdl/rv_dmem.sv
hdl/rv_core.sv
tests/tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_core -f project.f -o sim_core; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
